//--- rip_core.f
verilog/rip_pkg.sv
verilog/rip_regfile.sv
verilog/rip_fetch.sv
verilog/rip_decode.sv
verilog/rip_execute.sv
verilog/rip_memory.sv
verilog/rip_core.sv
verif/tb_clock.sv
verif/rip_core_assertions.sv
verif/tb_rip_core.sv

//--- Makefile
TOP := tb_rip_core

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f rip_core.f -o Vtb_rip_core
	@out="$$(./obj_dir/Vtb_rip_core)"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- verif/tb_rip_core.sv
`default_nettype none
`timescale 1ns/10ps

module tb_rip_core;
    import rip_pkg::*;

    localparam int IMEM_WORDS     = 64;
    localparam int DMEM_WORDS     = 64;
    // 64-word load plus two runs of about 40 cycles, with margin
    localparam int TIMEOUT_CYCLES = 400;

    logic       clk;
    logic       rst_n;
    logic       run;
    logic       busy;
    logic       imem_we;
    logic [5:0] imem_addr;
    word_t      imem_data;
    wb_t        retire;

    word_t      prog [IMEM_WORDS];
    wb_t        expected [$];
    string      names [$];
    int         cycles = 0;

    tb_clock clock_gen (
        .clk  (clk),
        .rst_n(rst_n)
    );

    rip_core #(
        .IMEM_WORDS(IMEM_WORDS),
        .DMEM_WORDS(DMEM_WORDS)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .busy     (busy),
        .imem_we  (imem_we),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .retire   (retire)
    );

    // rv32i instruction formats
    function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic word_t i_type(int imm, int rs1, int f3, int rd, logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic word_t s_type(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t j_type(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic word_t u_type(int imm, int rd, logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    task automatic report_mismatch(input string test, input string exp, input string act);
        $display("ERR %s: expected %s, actual %s", test, exp, act);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic assemble_program();
        // unused words hold addi x30, x0, index
        for (int i = 0; i < IMEM_WORDS; i++) begin
            prog[i] = i_type(i, 0, 0, 30, OPC_OP_IMM);
        end
        prog[0]  = u_type(32'h12345, 1, OPC_LUI);
        prog[1]  = i_type(32'h678, 0, 0, 2, OPC_OP_IMM);
        prog[2]  = r_type(0, 2, 1, 0, 3);
        prog[3]  = r_type(32, 2, 3, 0, 4);
        prog[4]  = r_type(0, 4, 3, 7, 5);
        prog[5]  = r_type(0, 5, 2, 6, 6);
        prog[6]  = r_type(0, 1, 6, 4, 7);
        prog[7]  = i_type(-1, 0, 0, 8, OPC_OP_IMM);
        // write to x0 must be dropped
        prog[8]  = i_type(5, 0, 0, 0, OPC_OP_IMM);
        prog[9]  = r_type(0, 8, 0, 0, 9);
        prog[10] = s_type(8, 3, 0, 2);
        prog[11] = i_type(8, 0, 2, 10, OPC_LOAD);
        // load-use on x10
        prog[12] = r_type(0, 2, 10, 0, 11);
        // beq x7, x2 taken to word 16
        prog[13] = b_type(12, 2, 7, 0);
        prog[14] = i_type(99, 0, 0, 20, OPC_OP_IMM);
        prog[15] = i_type(98, 0, 0, 21, OPC_OP_IMM);
        // bne x1, x1 falls through
        prog[16] = b_type(8, 1, 1, 1);
        // jal x12 to word 20
        prog[17] = j_type(12, 12);
        prog[18] = i_type(97, 0, 0, 22, OPC_OP_IMM);
        prog[19] = i_type(96, 0, 0, 23, OPC_OP_IMM);
        prog[20] = r_type(0, 11, 12, 0, 13);
        prog[21] = 32'h00100073;
    endtask

    task automatic add_expect(input string name, input bit writes, input int rd,
                              input word_t data, input bit ebreak);
        wb_t e;
        e           = '0;
        e.valid     = 1'b1;
        e.writes_rd = writes;
        e.rd        = writes ? rd[4:0] : 5'd0;
        e.data      = writes ? data : '0;
        e.is_ebreak = ebreak;
        expected.push_back(e);
        names.push_back(name);
    endtask

    task automatic list_retires();
        add_expect("lui", 1, 1, 32'h12345000, 0);
        add_expect("addi", 1, 2, 32'h00000678, 0);
        add_expect("add_fwd", 1, 3, 32'h12345678, 0);
        add_expect("sub_fwd", 1, 4, 32'h12345000, 0);
        add_expect("and", 1, 5, 32'h12345000, 0);
        add_expect("or", 1, 6, 32'h12345678, 0);
        add_expect("xor", 1, 7, 32'h00000678, 0);
        add_expect("addi_neg", 1, 8, 32'hffffffff, 0);
        add_expect("addi_x0", 0, 0, 32'h0, 0);
        add_expect("read_x0", 1, 9, 32'hffffffff, 0);
        add_expect("sw", 0, 0, 32'h0, 0);
        add_expect("lw", 1, 10, 32'h12345678, 0);
        add_expect("load_use", 1, 11, 32'h12345cf0, 0);
        add_expect("beq_taken", 0, 0, 32'h0, 0);
        add_expect("bne_not_taken", 0, 0, 32'h0, 0);
        add_expect("jal_link", 1, 12, 32'h00000048, 0);
        add_expect("jal_target", 1, 13, 32'h12345d38, 0);
        add_expect("ebreak", 0, 0, 32'h0, 1);
    endtask

    task automatic load_program();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= 6'(i);
            imem_data <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic expect_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (!busy && !retire.valid) else abort_run("core active while idle");
        end
    endtask

    task automatic check_retire(input string pass_name, input int idx);
        wb_t act;
        act = retire;
        // rd and data carry no meaning without a register write
        if (!act.writes_rd) begin
            act.rd   = '0;
            act.data = '0;
        end
        assert (idx < expected.size())
            else abort_run($sformatf("%s: retire beyond the end of the program", pass_name));
        assert (act == expected[idx])
            else report_mismatch({pass_name, "/", names[idx]},
                                 $sformatf("%h", expected[idx]), $sformatf("%h", act));
    endtask

    task automatic run_program(input string pass_name);
        int   idx;
        logic done;
        idx  = 0;
        done = 1'b0;
        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
        @(negedge clk);
        assert (busy) else abort_run("busy did not rise one cycle after run");
        while (!done) begin
            @(negedge clk);
            if (retire.valid) begin
                check_retire(pass_name, idx);
                done = retire.is_ebreak;
                idx++;
            end
        end
        @(negedge clk);
        assert (!busy) else abort_run("busy still high one cycle after ebreak retired");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    initial begin
        run       = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        assemble_program();
        list_retires();
        wait (rst_n);
        expect_idle(5);
        load_program();
        expect_idle(3);
        run_program("first_run");
        // nothing after ebreak may retire
        expect_idle(8);
        run_program("second_run");
        expect_idle(8);
        if (DUT.checks.idle_retire_failed || DUT.checks.run_start_failed ||
            DUT.checks.ebreak_stop_failed || DUT.checks.bubble_failed ||
            DUT.checks.flush_failed || DUT.checks.x0_write_failed) begin
            $display("a bound assertion failed during the run");
            $display("TEST FAIL");
            $fatal(1);
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verif/rip_core_assertions.sv
`default_nettype none
`timescale 1ns/10ps

module rip_core_assertions (
    input logic         clk,
    input logic         rst_n,
    input logic         run,
    input logic         busy,
    input logic         stall,
    input logic         flush,
    input rip_pkg::wb_t retire
);

    logic idle_retire_failed = 1'b0;
    logic run_start_failed   = 1'b0;
    logic ebreak_stop_failed = 1'b0;
    logic bubble_failed      = 1'b0;
    logic flush_failed       = 1'b0;
    logic x0_write_failed    = 1'b0;

    idle_has_no_retire: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !retire.valid)
        else begin
            idle_retire_failed = 1'b1;
            $error("retire seen while the core is idle");
        end

    run_starts_core: assert property (@(posedge clk) disable iff (!rst_n)
        run && !busy |=> busy)
        else begin
            run_start_failed = 1'b1;
            $error("busy did not rise after run");
        end

    // busy drops right after ebreak leaves write-back
    ebreak_ends_run: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && retire.is_ebreak |=> !busy)
        else begin
            ebreak_stop_failed = 1'b1;
            $error("busy still high after ebreak retired");
        end

    load_use_single_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !stall)
        else begin
            bubble_failed = 1'b1;
            $error("load-use stall lasted more than one cycle");
        end

    flush_kills_next: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !flush)
        else begin
            flush_failed = 1'b1;
            $error("flushed instruction redirected again");
        end

    x0_never_written: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && retire.writes_rd |-> retire.rd != 5'd0)
        else begin
            x0_write_failed = 1'b1;
            $error("retire wrote register x0");
        end

endmodule

bind rip_core rip_core_assertions checks (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .busy  (busy),
    .stall (stall),
    .flush (flush),
    .retire(retire)
);

`default_nettype wire

//--- verif/tb_clock.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held over the first 4 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verilog/rip_core.sv
`default_nettype none
`timescale 1ns/10ps

module rip_core #(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,

    // run control
    input  logic                          run,
    output logic                          busy,

    // program load port, idle only
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  rip_pkg::word_t                imem_data,

    output rip_pkg::wb_t                  retire
);
    import rip_pkg::*;

    logic      if_valid;
    word_t     if_pc;
    word_t     if_inst;
    logic      stall;
    logic      halt_fetch;
    logic      flush;
    redirect_t redirect;
    reg_num_t  rs1_num;
    reg_num_t  rs2_num;
    word_t     rs1_data;
    word_t     rs2_data;
    de_ex_t    de_ex;
    ex_ma_t    ex_ma;
    wb_t       wb;

    rip_fetch #(
        .IMEM_WORDS(IMEM_WORDS)
    ) fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .stall     (stall),
        .halt_fetch(halt_fetch),
        .redirect  (redirect),
        .wb        (wb),
        .busy      (busy),
        .if_valid  (if_valid),
        .if_pc     (if_pc),
        .if_inst   (if_inst)
    );

    rip_decode decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .if_valid  (if_valid),
        .if_pc     (if_pc),
        .if_inst   (if_inst),
        .flush     (flush),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wb        (wb),
        .rs1_num   (rs1_num),
        .rs2_num   (rs2_num),
        .stall     (stall),
        .halt_fetch(halt_fetch),
        .de_ex     (de_ex)
    );

    rip_regfile regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1_num (rs1_num),
        .rs2_num (rs2_num),
        .wb      (wb),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    rip_execute execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .de_ex   (de_ex),
        .wb      (wb),
        .ex_ma   (ex_ma),
        .redirect(redirect),
        .flush   (flush)
    );

    rip_memory #(
        .DMEM_WORDS(DMEM_WORDS)
    ) memory (
        .clk  (clk),
        .rst_n(rst_n),
        .ex_ma(ex_ma),
        .wb   (wb)
    );

    // every write-back is visible outside
    assign retire = wb;

endmodule

`default_nettype wire

//--- verilog/rip_memory.sv
`default_nettype none
`timescale 1ns/10ps

module rip_memory #(
    parameter int DMEM_WORDS = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  rip_pkg::ex_ma_t ex_ma,
    output rip_pkg::wb_t    wb
);
    import rip_pkg::*;

    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    word_t                dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0]   dm_idx;
    logic                 wb_valid;
    logic                 wb_writes_rd;
    logic                 wb_is_load;
    logic                 wb_is_ebreak;
    reg_num_t             wb_rd;
    word_t                wb_result;
    word_t                load_data;

    // word addressed, low two bits ignored
    assign dm_idx = ex_ma.result[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (ex_ma.valid && ex_ma.is_store) begin
            dmem[dm_idx] <= ex_ma.store_data;
        end
        if (ex_ma.valid && ex_ma.is_load) begin
            load_data <= dmem[dm_idx];
        end
        wb_rd        <= ex_ma.rd;
        wb_result    <= ex_ma.result;
        wb_writes_rd <= ex_ma.writes_rd;
        wb_is_load   <= ex_ma.is_load;
        wb_is_ebreak <= ex_ma.is_ebreak;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_ma.valid;
        end
    end

    assign wb.valid     = wb_valid;
    assign wb.writes_rd = wb_writes_rd;
    assign wb.rd        = wb_rd;
    assign wb.data      = wb_is_load ? load_data : wb_result;
    assign wb.is_ebreak = wb_is_ebreak;

endmodule

`default_nettype wire

//--- verilog/rip_execute.sv
`default_nettype none
`timescale 1ns/10ps

module rip_execute (
    input  logic               clk,
    input  logic               rst_n,
    input  rip_pkg::de_ex_t    de_ex,
    input  rip_pkg::wb_t       wb,
    output rip_pkg::ex_ma_t    ex_ma,
    output rip_pkg::redirect_t redirect,
    output logic               flush
);
    import rip_pkg::*;

    word_t  op_a;
    word_t  rs2_fwd;
    word_t  op_b;
    word_t  alu_out;
    logic   taken;
    ex_ma_t ex_next;

    // newest producer wins: memory stage first, then write-back
    function automatic word_t fwd(input reg_num_t num, input word_t reg_val,
                                  input ex_ma_t ma, input wb_t w);
        word_t val;
        val = reg_val;
        if (ma.valid && ma.writes_rd && !ma.is_load && ma.rd == num) begin
            val = ma.result;
        end else if (w.valid && w.writes_rd && w.rd == num) begin
            val = w.data;
        end
        return val;
    endfunction

    always_comb begin
        op_a    = fwd(de_ex.rs1, de_ex.rs1_val, ex_ma, wb);
        rs2_fwd = fwd(de_ex.rs2, de_ex.rs2_val, ex_ma, wb);
        op_b    = de_ex.use_imm ? de_ex.imm : rs2_fwd;

        alu_out = '0;
        taken   = 1'b0;
        case (de_ex.op)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_PASS: alu_out = op_b;
            ALU_BEQ:  taken = (op_a == rs2_fwd);
            ALU_BNE:  taken = (op_a != rs2_fwd);
            ALU_JAL: begin
                // link address
                alu_out = de_ex.pc + 32'd4;
                taken   = 1'b1;
            end
            default: alu_out = '0;
        endcase
    end

    assign redirect.taken  = de_ex.valid && taken;
    assign redirect.target = de_ex.pc + de_ex.imm;
    // kills the two younger instructions in fetch and decode
    assign flush = redirect.taken;

    always_comb begin
        ex_next            = '0;
        ex_next.valid      = de_ex.valid;
        ex_next.rd         = de_ex.rd;
        ex_next.result     = alu_out;
        ex_next.store_data = rs2_fwd;
        ex_next.is_load    = de_ex.is_load;
        ex_next.is_store   = de_ex.is_store;
        ex_next.writes_rd  = de_ex.writes_rd;
        ex_next.is_ebreak  = de_ex.is_ebreak;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_ma.valid <= 1'b0;
        end else begin
            ex_ma <= ex_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rip_decode.sv
`default_nettype none
`timescale 1ns/10ps

module rip_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              if_valid,
    input  rip_pkg::word_t    if_pc,
    input  rip_pkg::word_t    if_inst,
    input  logic              flush,
    input  rip_pkg::word_t    rs1_data,
    input  rip_pkg::word_t    rs2_data,
    input  rip_pkg::wb_t      wb,
    output rip_pkg::reg_num_t rs1_num,
    output rip_pkg::reg_num_t rs2_num,
    output logic              stall,
    output logic              halt_fetch,
    output rip_pkg::de_ex_t   de_ex
);
    import rip_pkg::*;

    logic       [6:0] opcode;
    logic       [2:0] funct3;
    logic             uses_rs1;
    logic             uses_rs2;
    logic             writes;
    logic             in_valid;
    logic             ebreak_seen;
    logic             ebreak_now;
    de_ex_t           de_next;

    assign opcode  = if_inst[6:0];
    assign funct3  = if_inst[14:12];
    assign rs1_num = if_inst[19:15];
    assign rs2_num = if_inst[24:20];

    // nothing behind a decoded ebreak may enter execute
    assign in_valid = if_valid && !ebreak_seen;

    always_comb begin
        de_next         = '0;
        de_next.pc      = if_pc;
        de_next.op      = ALU_ADD;
        de_next.rs1     = rs1_num;
        de_next.rs2     = rs2_num;
        de_next.rs1_val = rs1_data;
        de_next.rs2_val = rs2_data;
        de_next.rd      = if_inst[11:7];
        uses_rs1        = 1'b0;
        uses_rs2        = 1'b0;
        writes          = 1'b0;
        case (opcode)
            OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                writes   = 1'b1;
                case (funct3)
                    3'b111:  de_next.op = ALU_AND;
                    3'b110:  de_next.op = ALU_OR;
                    3'b100:  de_next.op = ALU_XOR;
                    default: de_next.op = if_inst[30] ? ALU_SUB : ALU_ADD;
                endcase
            end
            OPC_OP_IMM: begin
                uses_rs1        = 1'b1;
                writes          = 1'b1;
                de_next.use_imm = 1'b1;
                de_next.imm     = {{20{if_inst[31]}}, if_inst[31:20]};
            end
            OPC_LUI: begin
                writes          = 1'b1;
                de_next.op      = ALU_PASS;
                de_next.use_imm = 1'b1;
                de_next.imm     = {if_inst[31:12], 12'h000};
            end
            OPC_LOAD: begin
                uses_rs1        = 1'b1;
                writes          = 1'b1;
                de_next.use_imm = 1'b1;
                de_next.is_load = 1'b1;
                de_next.imm     = {{20{if_inst[31]}}, if_inst[31:20]};
            end
            OPC_STORE: begin
                uses_rs1         = 1'b1;
                uses_rs2         = 1'b1;
                de_next.use_imm  = 1'b1;
                de_next.is_store = 1'b1;
                de_next.imm      = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
            end
            OPC_BRANCH: begin
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                de_next.op  = funct3[0] ? ALU_BNE : ALU_BEQ;
                de_next.imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7],
                               if_inst[30:25], if_inst[11:8], 1'b0};
            end
            OPC_JAL: begin
                writes      = 1'b1;
                de_next.op  = ALU_JAL;
                de_next.imm = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12],
                               if_inst[20], if_inst[30:21], 1'b0};
            end
            OPC_SYSTEM: de_next.is_ebreak = 1'b1;
            default: ;
        endcase
        // x0 is never a destination
        de_next.writes_rd = writes && (de_next.rd != '0);

        // load-use: the load is one stage ahead in execute
        stall = in_valid && de_ex.valid && de_ex.is_load && de_ex.writes_rd &&
                ((uses_rs1 && rs1_num == de_ex.rd) || (uses_rs2 && rs2_num == de_ex.rd));
        de_next.valid = in_valid && !flush && !stall;
    end

    assign ebreak_now = in_valid && !flush && de_next.is_ebreak;
    assign halt_fetch = ebreak_now || ebreak_seen;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_ex.valid <= 1'b0;
            ebreak_seen <= 1'b0;
        end else begin
            de_ex <= de_next;
            if (wb.valid && wb.is_ebreak) begin
                ebreak_seen <= 1'b0;
            end else if (ebreak_now) begin
                ebreak_seen <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rip_fetch.sv
`default_nettype none
`timescale 1ns/10ps

module rip_fetch #(
    parameter int IMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  rip_pkg::word_t                imem_data,
    input  logic                          stall,
    input  logic                          halt_fetch,
    input  rip_pkg::redirect_t            redirect,
    input  rip_pkg::wb_t                  wb,
    output logic                          busy,
    output logic                          if_valid,
    output rip_pkg::word_t                if_pc,
    output rip_pkg::word_t                if_inst
);
    import rip_pkg::*;

    localparam int IMEM_AW = $clog2(IMEM_WORDS);

    core_mode_t mode;
    word_t      pc;
    word_t      imem [IMEM_WORDS];
    logic       issue;

    assign busy  = (mode != IDLE);
    // a new instruction leaves fetch this cycle
    assign issue = (mode == RUNNING) && !halt_fetch && !stall && !redirect.taken;

    always_ff @(posedge clk) begin
        if (imem_we && mode == IDLE) begin
            imem[imem_addr] <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode     <= IDLE;
            pc       <= '0;
            if_valid <= 1'b0;
        end else begin
            case (mode)
                IDLE: begin
                    if (run) begin
                        mode <= RUNNING;
                        pc   <= '0;
                    end
                end
                RUNNING: begin
                    if (halt_fetch) begin
                        mode <= DRAINING;
                    end
                end
                DRAINING: begin
                    // ebreak has reached write-back
                    if (wb.valid && wb.is_ebreak) begin
                        mode <= IDLE;
                    end
                end
                default: mode <= IDLE;
            endcase

            if (redirect.taken) begin
                pc <= redirect.target;
            end else if (issue) begin
                pc <= pc + 32'd4;
            end

            // on a stall decode keeps the current instruction
            if (!stall) begin
                if_valid <= issue;
            end
        end
    end

    // synchronous instruction read
    always_ff @(posedge clk) begin
        if (issue) begin
            if_inst <= imem[pc[IMEM_AW+1:2]];
            if_pc   <= pc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rip_regfile.sv
`default_nettype none
`timescale 1ns/10ps

module rip_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rip_pkg::reg_num_t rs1_num,
    input  rip_pkg::reg_num_t rs2_num,
    input  rip_pkg::wb_t      wb,
    output rip_pkg::word_t    rs1_data,
    output rip_pkg::word_t    rs2_data
);
    import rip_pkg::*;

    word_t regs [32];
    logic  wen;

    assign wen = wb.valid && wb.writes_rd && (wb.rd != '0);

    // write-first, x0 reads as zero
    assign rs1_data = (rs1_num == '0) ? '0 : (wen && wb.rd == rs1_num) ? wb.data : regs[rs1_num];
    assign rs2_data = (rs2_num == '0) ? '0 : (wen && wb.rd == rs2_num) ? wb.data : regs[rs2_num];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rip_pkg.sv
`default_nettype none

package rip_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_num_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS,
        ALU_BEQ,
        ALU_BNE,
        ALU_JAL
    } alu_op_t;

    typedef enum logic [1:0] {
        IDLE,
        RUNNING,
        DRAINING
    } core_mode_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        alu_op_t  op;
        reg_num_t rs1;
        reg_num_t rs2;
        word_t    rs1_val;
        word_t    rs2_val;
        reg_num_t rd;
        word_t    imm;
        logic     use_imm;
        logic     is_load;
        logic     is_store;
        logic     writes_rd;
        logic     is_ebreak;
    } de_ex_t;

    typedef struct packed {
        logic     valid;
        reg_num_t rd;
        // alu result, or address for loads and stores
        word_t    result;
        word_t    store_data;
        logic     is_load;
        logic     is_store;
        logic     writes_rd;
        logic     is_ebreak;
    } ex_ma_t;

    typedef struct packed {
        logic     valid;
        logic     writes_rd;
        reg_num_t rd;
        word_t    data;
        logic     is_ebreak;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // rv32i major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire
